//--- verif/vector_store_buffer_tests.txt
# C vl sew unit | B base stride | U base | W lane0..lane7 | R word | A addr xfer | X
# F flags, bit 2 write_done, bit 1 read_done, bit 0 read_rdy
A 00000000 000
F 6
B 00001000 00000000
C 00a 2 1
A 00001000 028
F 0
W 30201000 31211101 32221202 33231303 34241404 35251505 36261606 37271707
F 5
W 70605040 71615141 72625242 73635343 74645444 75655545 76665646 77675747
R 03020100
R 07060504
R 13121110
R 17161514
R 23222120
R 27262524
R 33323130
R 37363534
R 43424140
F 7
X
F 0
R 03020100
B 00002002 00000005
C 004 1 0
X
A 00002000 004
W 30201000 31211101 32221202 33231303 34241404 35251505 36261606 37271707
R 01000302
R 03020100
F 5
R 05040706
R 07060504
F 7
U 00000000
A 00002004 004
R 10131211
U 00000000
A 0000200c 004
C 00a 2 1
U 00003001
A 00003000 028

//--- vector_store_buffer.f
+incdir+hw
hw/lane_ram.sv
hw/vbuf_pkg.sv
hw/lane_byte_buffer.sv
hw/store_buffer_counters.sv
hw/store_addr_gen.sv
hw/vector_store_buffer.sv
verif/vector_store_buffer_checker.sv
verif/vector_store_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the store buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module vector_store_buffer_tb \
  -f vector_store_buffer.f \
  --Mdir obj_dir

./obj_dir/Vvector_store_buffer_tb 2>&1 | tee sim.log || true

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1

//--- verif/vector_store_buffer_tb.sv
// Runs the command lines of verif/vector_store_buffer_tests.txt, started from the project root.
// All fields are hex; lines starting with # are skipped.
`timescale 1ns/1ps
`include "vbuf_macros.svh"

module vector_store_buffer_tb import vbuf_pkg::*; ();

  localparam string TESTS_FILE = "verif/vector_store_buffer_tests.txt";

  logic       clk = 1'b0;
  logic       rstn;
  store_cfg_t store_cfg;
  logic       store_cfg_update;
  addr_t      store_base;
  addr_t      store_stride;
  logic       store_base_set;
  logic       store_base_update;
  logic       store_cntr_rst;
  logic       sbuff_wen;
  logic       sdbuff_ren;
  lane_bus_t  vlane_store_data;
  wr_req_t    wr_req;
  word_t      wr_tdata;
  logic       write_done;
  logic       read_done;
  logic       read_rdy;
  int         n_lines = 0;

  always #5 clk = ~clk;

  vector_store_buffer u_vector_store_buffer (
    .clk                 (clk),
    .rstn                (rstn),
    .store_cfg_i         (store_cfg),
    .store_cfg_update_i  (store_cfg_update),
    .store_base_i        (store_base),
    .store_stride_i      (store_stride),
    .store_base_set_i    (store_base_set),
    .store_base_update_i (store_base_update),
    .store_cntr_rst_i    (store_cntr_rst),
    .sbuff_wen_i         (sbuff_wen),
    .sdbuff_ren_i        (sdbuff_ren),
    .vlane_store_data_i  (vlane_store_data),
    .wr_req_o            (wr_req),
    .wr_tdata_o          (wr_tdata),
    .write_done_o        (write_done),
    .read_done_o         (read_done),
    .read_rdy_o          (read_rdy)
  );

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_req(input string name, input wr_req_t got, input wr_req_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  // Flags are {write_done, read_done, read_rdy}
  task automatic check_flags(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  // Strobes last one cycle
  task automatic end_strobes();
    @(posedge clk);
    store_cfg_update  <= 1'b0;
    store_base_set    <= 1'b0;
    store_base_update <= 1'b0;
    store_cntr_rst    <= 1'b0;
    sbuff_wen         <= 1'b0;
    sdbuff_ren        <= 1'b0;
  endtask

  ////////////////////
  // Command player
  ////////////////////

  initial begin
    int         fd;
    int         n;
    string      line;
    logic [7:0] cmd;
    byte_cnt_t  cnt;
    sew_t       sew;
    logic       unit;
    addr_t      base;
    addr_t      stride;
    word_t      word;
    lane_bus_t  lanes;
    wr_req_t    req;
    logic [2:0] flags;
    rstn              = 1'b0;
    store_cfg         = '0;
    store_cfg_update  = 1'b0;
    store_base        = '0;
    store_stride      = '0;
    store_base_set    = 1'b0;
    store_base_update = 1'b0;
    store_cntr_rst    = 1'b0;
    sbuff_wen         = 1'b0;
    sdbuff_ren        = 1'b0;
    vlane_store_data  = '0;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      fail_stop("Cannot open the tests file");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) n_lines = n_lines + 1;
    end
    $fclose(fd);
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    fd = $fopen(TESTS_FILE, "r");
    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": n = $fgets(line, fd);
        "C": begin
          n = $fscanf(fd, "%h %h %h", cnt, sew, unit);
          @(posedge clk);
          store_cfg        <= '{vl: cnt, sew: sew, unit_stride: unit};
          store_cfg_update <= 1'b1;
          end_strobes();
        end
        "B": begin
          n = $fscanf(fd, "%h %h", base, stride);
          @(posedge clk);
          store_base     <= base;
          store_stride   <= stride;
          store_base_set <= 1'b1;
          end_strobes();
        end
        "U": begin
          n = $fscanf(fd, "%h", base);
          @(posedge clk);
          store_base        <= base;
          store_base_update <= 1'b1;
          end_strobes();
        end
        "W": begin
          for (int i = 0; i < `VBUF_VLANE_NUM; i++) begin
            n = $fscanf(fd, "%h", word);
            lanes[i] = word;
          end
          @(posedge clk);
          vlane_store_data <= lanes;
          sbuff_wen        <= 1'b1;
          end_strobes();
        end
        "R": begin
          n = $fscanf(fd, "%h", word);
          @(posedge clk);
          sdbuff_ren <= 1'b1;
          end_strobes();
          // Word for the old counter value shows after this edge
          @(negedge clk);
          check_word("wr_tdata_o", wr_tdata, word);
        end
        "A": begin
          n = $fscanf(fd, "%h %h", base, cnt);
          req.addr      = base;
          req.xfer_size = cnt;
          @(negedge clk);
          check_req("wr_req_o", wr_req, req);
        end
        "F": begin
          n = $fscanf(fd, "%h", flags);
          @(negedge clk);
          check_flags("done_rdy_flags", {write_done, read_done, read_rdy}, flags);
        end
        "X": begin
          @(posedge clk);
          store_cntr_rst <= 1'b1;
          end_strobes();
        end
        default: fail_stop($sformatf("Unknown command %c in the tests file", cmd));
      endcase
    end
    $fclose(fd);
    repeat (2) @(posedge clk);
    if (u_vector_store_buffer.u_vector_store_buffer_checker.fail_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      fail_stop("The checker reported assertion failures");
    end
  end

  // Watchdog allows 20 cycles per line of the tests file
  initial begin
    wait (n_lines > 0);
    repeat (n_lines * 20) @(posedge clk);
    fail_stop("Watchdog expired before the tests finished");
  end

endmodule

//--- verif/vector_store_buffer_checker.sv
// Concurrent checks on the store buffer outputs, bound to the top level.
// Assertions must be enabled in the simulator.
`timescale 1ns/1ps

module vector_store_buffer_checker import vbuf_pkg::*; (
  input logic       clk,
  input logic       rstn,
  input logic       read_rdy_i,
  input wr_req_t    wr_req_i,
  input store_cfg_t cfg_i
);

  int fail_cnt = 0;

  // Both counters are zero after reset, nothing is unread
  a_rdy_after_reset: assert property (@(posedge clk) !rstn |=> !read_rdy_i)
    else begin
      $error("read_rdy_o high in the cycle after reset");
      fail_cnt++;
    end

  a_addr_aligned: assert property (@(posedge clk) disable iff (!rstn)
    wr_req_i.addr[1:0] == 2'b00)
    else begin
      $error("wr_req_o.addr is not word aligned");
      fail_cnt++;
    end

  // Strided stores move one word per request
  a_strided_size: assert property (@(posedge clk) disable iff (!rstn)
    (!cfg_i.unit_stride && (cfg_i.vl << cfg_i.sew) != '0) |-> wr_req_i.xfer_size == byte_cnt_t'(4))
    else begin
      $error("wr_req_o.xfer_size is not 4 in strided mode");
      fail_cnt++;
    end

endmodule

bind vector_store_buffer vector_store_buffer_checker u_vector_store_buffer_checker (
  .clk        (clk),
  .rstn       (rstn),
  .read_rdy_i (read_rdy_o),
  .wr_req_i   (wr_req_o),
  .cfg_i      (cfg)
);

//--- hw/vector_store_buffer.sv
// Store half of the lane buffer array. No handshake on any port:
// the controller paces writes and reads with single-cycle strobes.
`timescale 1ns/1ps

module vector_store_buffer import vbuf_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  // Controller configuration
  input  store_cfg_t store_cfg_i,
  input  logic       store_cfg_update_i,
  input  addr_t      store_base_i,
  input  addr_t      store_stride_i,
  input  logic       store_base_set_i,
  input  logic       store_base_update_i,
  // Controller strobes
  input  logic       store_cntr_rst_i,
  input  logic       sbuff_wen_i,
  input  logic       sdbuff_ren_i,
  // Lane data
  input  lane_bus_t  vlane_store_data_i,
  // AXI write side
  output wr_req_t    wr_req_o,
  output word_t      wr_tdata_o,
  // Status levels
  output logic       write_done_o,
  output logic       read_done_o,
  output logic       read_rdy_o
);

  store_cfg_t cfg;
  logic [1:0] base_low;
  row_addr_t  wr_row;
  byte_cnt_t  rd_cnt;

  store_addr_gen u_store_addr_gen (
    .clk                 (clk),
    .rstn                (rstn),
    .store_cfg_i         (store_cfg_i),
    .store_cfg_update_i  (store_cfg_update_i),
    .store_base_i        (store_base_i),
    .store_stride_i      (store_stride_i),
    .store_base_set_i    (store_base_set_i),
    .store_base_update_i (store_base_update_i),
    .cfg_o               (cfg),
    .base_low_o          (base_low),
    .wr_req_o            (wr_req_o)
  );

  store_buffer_counters u_store_buffer_counters (
    .clk              (clk),
    .rstn             (rstn),
    .cfg_i            (cfg),
    .store_cntr_rst_i (store_cntr_rst_i),
    .sbuff_wen_i      (sbuff_wen_i),
    .sdbuff_ren_i     (sdbuff_ren_i),
    .wr_row_o         (wr_row),
    .rd_cnt_o         (rd_cnt),
    .write_done_o     (write_done_o),
    .read_done_o      (read_done_o),
    .read_rdy_o       (read_rdy_o)
  );

  lane_byte_buffer u_lane_byte_buffer (
    .clk                (clk),
    .rstn               (rstn),
    .vlane_store_data_i (vlane_store_data_i),
    .sbuff_wen_i        (sbuff_wen_i),
    .wr_row_i           (wr_row),
    .rd_cnt_i           (rd_cnt),
    .base_low_i         (base_low),
    .wr_tdata_o         (wr_tdata_o)
  );

endmodule

//--- hw/store_addr_gen.sv
// Base address and stride for unit-stride and strided stores.
// Strided transfers are single words; a zero vl requests nothing.
`timescale 1ns/1ps

module store_addr_gen import vbuf_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  store_cfg_t store_cfg_i,
  input  logic       store_cfg_update_i,
  input  addr_t      store_base_i,
  input  addr_t      store_stride_i,
  input  logic       store_base_set_i,
  input  logic       store_base_update_i,
  output store_cfg_t cfg_o,
  output logic [1:0] base_low_o,
  output wr_req_t    wr_req_o
);

  store_cfg_t cfg_q;
  addr_t      base_q;
  addr_t      stride_q;
  byte_cnt_t  total_bytes;

  ////////////////////
  // Configuration latch
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg_q <= '0;
    end else if (store_cfg_update_i) begin
      cfg_q <= store_cfg_i;
    end
  end

  ////////////////////
  // Base stepping
  ////////////////////

  // Set takes priority over update
  always_ff @(posedge clk) begin
    if (!rstn) begin
      base_q   <= '0;
      stride_q <= '0;
    end else if (store_base_set_i) begin
      base_q   <= store_base_i;
      stride_q <= store_stride_i;
    end else if (store_base_update_i) begin
      if (cfg_q.unit_stride) begin
        base_q <= store_base_i;
      end else begin
        base_q <= base_q + stride_q;
      end
    end
  end

  ////////////////////
  // Request outputs
  ////////////////////

  assign total_bytes = cfg_total_bytes(cfg_q);

  // Word-aligned address, the data path rotates bytes into place
  assign wr_req_o.addr = {base_q[31:2], 2'b00};

  always_comb begin
    if (cfg_q.unit_stride) begin
      wr_req_o.xfer_size = total_bytes;
    end else if (total_bytes == '0) begin
      wr_req_o.xfer_size = '0;
    end else begin
      wr_req_o.xfer_size = byte_cnt_t'(4);
    end
  end

  assign cfg_o      = cfg_q;
  assign base_low_o = base_q[1:0];

endmodule

//--- hw/store_buffer_counters.sv
// Write and read byte counters of the store buffer.
// A zero byte total reads as complete on both done levels.
`timescale 1ns/1ps
`include "vbuf_macros.svh"

module store_buffer_counters import vbuf_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  store_cfg_t cfg_i,
  input  logic       store_cntr_rst_i,
  input  logic       sbuff_wen_i,
  input  logic       sdbuff_ren_i,
  output row_addr_t  wr_row_o,
  output byte_cnt_t  rd_cnt_o,
  output logic       write_done_o,
  output logic       read_done_o,
  output logic       read_rdy_o
);

  // Byte offset of the row field in a counter
  localparam int ROW_LSB = `VBUF_LANE_SEL_W + 2;

  // One write strobe fills a full row across all lanes
  localparam byte_cnt_t ROW_BYTES = byte_cnt_t'(4 * `VBUF_VLANE_NUM);

  byte_cnt_t total_bytes;
  byte_cnt_t wr_cnt;
  byte_cnt_t wr_cnt_next;
  byte_cnt_t rd_cnt;
  byte_cnt_t rd_cnt_next;
  byte_cnt_t rd_step;

  assign total_bytes = cfg_total_bytes(cfg_i);

  ////////////////////
  // Write counter
  ////////////////////

  assign wr_cnt_next = wr_cnt + ROW_BYTES;

  always_ff @(posedge clk) begin
    if (!rstn || store_cntr_rst_i) begin
      wr_cnt <= '0;
    end else if (sbuff_wen_i) begin
      wr_cnt <= wr_cnt_next;
    end
  end

  ////////////////////
  // Read counter
  ////////////////////

  // Unit-stride reads whole words, strided reads one element
  assign rd_step     = cfg_i.unit_stride ? byte_cnt_t'(4) : (byte_cnt_t'(1) << cfg_i.sew);
  assign rd_cnt_next = rd_cnt + rd_step;

  always_ff @(posedge clk) begin
    if (!rstn || store_cntr_rst_i) begin
      rd_cnt <= '0;
    end else if (sdbuff_ren_i) begin
      rd_cnt <= rd_cnt_next;
    end
  end

  // Levels
  assign write_done_o = (wr_cnt_next >= total_bytes);
  assign read_done_o  = (rd_cnt_next >= total_bytes);
  assign read_rdy_o   = (wr_cnt > rd_cnt);

  assign wr_row_o = wr_cnt[ROW_LSB +: `VBUF_ROW_AW];
  assign rd_cnt_o = rd_cnt;

endmodule

//--- hw/lane_byte_buffer.sv
// Lane RAMs holding a store in byte-address order.
// Read data lags the read counter by one cycle; base_low is sampled at output.
`timescale 1ns/1ps
`include "vbuf_macros.svh"

module lane_byte_buffer import vbuf_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  lane_bus_t  vlane_store_data_i,
  input  logic       sbuff_wen_i,
  input  row_addr_t  wr_row_i,
  input  byte_cnt_t  rd_cnt_i,
  input  logic [1:0] base_low_i,
  output word_t      wr_tdata_o
);

  localparam int NLANE   = `VBUF_VLANE_NUM;
  localparam int ROW_LSB = `VBUF_LANE_SEL_W + 2;

  word_t                     ram_rdata [NLANE];
  row_addr_t                 rd_row;
  logic [ROW_LSB-1:0]        rd_low_q;
  lane_sel_t                 rd_col;
  word_t                     sel_word;
  logic [1:0]                rot_amt;

  assign rd_row = rd_cnt_i[ROW_LSB +: `VBUF_ROW_AW];

  ////////////////////
  // Byte transpose and lane RAMs
  ////////////////////

  for (genvar v = 0; v < NLANE; v++) begin : g_lane
    word_t ram_wdata;

    // Byte k of column v holds store byte 4v+k
    always_comb begin
      for (int k = 0; k < 4; k++) begin
        ram_wdata[8*k +: 8] =
          vlane_store_data_i[(4*v + k) % NLANE][8*((4*v + k) / NLANE) +: 8];
      end
    end

    lane_ram #(
      .DEPTH (`VBUF_BUFF_DEPTH),
      .WIDTH (32)
    ) u_lane_ram (
      .clk     (clk),
      .we_i    (sbuff_wen_i),
      .waddr_i (wr_row_i),
      .wdata_i (ram_wdata),
      .raddr_i (rd_row),
      .rdata_o (ram_rdata[v])
    );
  end

  ////////////////////
  // Word select and rotation
  ////////////////////

  // Column and byte offset follow the RAM read by one cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_low_q <= '0;
    end else begin
      rd_low_q <= rd_cnt_i[ROW_LSB-1:0];
    end
  end

  assign rd_col   = rd_low_q[2 +: `VBUF_LANE_SEL_W];
  assign sel_word = ram_rdata[rd_col];

  // Move the element to the byte lane of the target address
  assign rot_amt = base_low_i - rd_low_q[1:0];

  always_comb begin
    case (rot_amt)
      2'd1:    wr_tdata_o = {sel_word[23:0], sel_word[31:24]};
      2'd2:    wr_tdata_o = {sel_word[15:0], sel_word[31:16]};
      2'd3:    wr_tdata_o = {sel_word[7:0], sel_word[31:8]};
      default: wr_tdata_o = sel_word;
    endcase
  end

endmodule

//--- hw/vbuf_pkg.sv
// Types shared by the store path of the lane buffer array.
// Sizes come from the macros header.
`include "vbuf_macros.svh"

package vbuf_pkg;

  // Bus and lane words, byte addresses
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // Element width code, 0 = 8, 1 = 16, 2 = 32 bits
  typedef logic [1:0] sew_t;

  typedef logic [`VBUF_CNT_W-1:0] byte_cnt_t;
  typedef logic [`VBUF_ROW_AW-1:0] row_addr_t;
  typedef logic [`VBUF_LANE_SEL_W-1:0] lane_sel_t;

  // One word per lane, lane 0 in the low bits
  typedef word_t [`VBUF_VLANE_NUM-1:0] lane_bus_t;

  typedef struct packed {
    byte_cnt_t vl;
    sew_t      sew;
    logic      unit_stride;
  } store_cfg_t;

  // Write request toward the AXI write master
  typedef struct packed {
    addr_t     addr;
    byte_cnt_t xfer_size;
  } wr_req_t;

  // Total bytes of one store
  function automatic byte_cnt_t cfg_total_bytes(input store_cfg_t cfg);
    return cfg.vl << cfg.sew;
  endfunction

endpackage

//--- hw/lane_ram.sv
// Simple dual-port RAM on one clock, registered read.
// Contents are undefined until written; read during write returns old data.
`timescale 1ns/1ps

module lane_ram #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

//--- hw/vbuf_macros.svh
// Store buffer sizing. VLEN must be a multiple of 32 x lane count.
// The lane count must be a power of two and at least 4.
`ifndef VBUF_MACROS_SVH
`define VBUF_MACROS_SVH

////////////////////
// Base sizes
////////////////////

// Number of vector lanes feeding the buffer
`define VBUF_VLANE_NUM 8

// Vector register length in bits
`define VBUF_VLEN 512

////////////////////
// Derived sizes
////////////////////

// Rows per lane RAM, one 32-bit word per row
`define VBUF_BUFF_DEPTH ((`VBUF_VLEN / 4) / `VBUF_VLANE_NUM)
`define VBUF_ROW_AW $clog2(`VBUF_BUFF_DEPTH)
`define VBUF_LANE_SEL_W $clog2(`VBUF_VLANE_NUM)

// Byte counters must hold VLEN bytes plus one
`define VBUF_CNT_W ($clog2(`VBUF_VLEN) + 1)

`endif
